/* exe_pkg.sv */
package exe_pkg;

    localparam int XLEN     = 32;
    localparam int ROB_ID_W = 5;

    typedef logic [XLEN-1:0]     t_data;
    typedef logic [ROB_ID_W-1:0] t_rob_id;

    // Zero encoding is the invalid op so a cleared packet never executes
    typedef enum logic [4:0] {
        U_INVALID = 5'd0,
        U_ADD     = 5'd1,
        U_SUB     = 5'd2,
        U_AND     = 5'd3,
        U_OR      = 5'd4,
        U_XOR     = 5'd5,
        U_SLL     = 5'd6,
        U_SRL     = 5'd7,
        U_SRA     = 5'd8,
        U_SLT     = 5'd9,
        U_SLTU    = 5'd10,
        U_LUI     = 5'd11,
        U_BEQ     = 5'd16,
        U_BNE     = 5'd17,
        U_BLT     = 5'd18,
        U_BGE     = 5'd19,
        U_BLTU    = 5'd20,
        U_BGEU    = 5'd21,
        U_JAL     = 5'd22,
        U_JALR    = 5'd23
    } t_uop;

    // Source of the second operand
    typedef enum logic [1:0] {
        OP_REG  = 2'd0,
        OP_IMM  = 2'd1,
        OP_ZERO = 2'd2
    } t_optype;

    typedef struct packed {
        t_uop    uop;
        t_optype src2_type;
        t_data   src1_val;
        t_data   src2_val;
        t_data   imm;
        t_data   pc;
        logic    pred_taken;
        t_rob_id robid;
    } t_iss_pkt;

    typedef struct packed {
        t_rob_id robid;
        t_data   result;
        logic    mispred;
        logic    killed;
    } t_rob_result;

    function automatic logic is_alu_uop(t_uop uop);
        return uop inside {U_ADD, U_SUB, U_AND, U_OR, U_XOR, U_SLL, U_SRL,
                           U_SRA, U_SLT, U_SLTU, U_LUI};
    endfunction

    function automatic logic is_br_uop(t_uop uop);
        return uop inside {U_BEQ, U_BNE, U_BLT, U_BGE, U_BLTU, U_BGEU,
                           U_JAL, U_JALR};
    endfunction

endpackage

/* ialu.sv */
module ialu
    import exe_pkg::*;
(
    input  t_uop  uop,
    input  t_data src1,
    input  t_data src2,
    output logic  resvld,
    output t_data result
);

    logic [4:0] shamt;

    // Only the low five bits matter for a 32-bit shift
    assign shamt  = src2[4:0];
    assign resvld = is_alu_uop(uop);

    always_comb begin
        result = '0;
        case (uop)
            U_ADD: begin
                result = src1 + src2;
            end
            U_SUB: begin
                result = src1 - src2;
            end
            U_AND: begin
                result = src1 & src2;
            end
            U_OR: begin
                result = src1 | src2;
            end
            U_XOR: begin
                result = src1 ^ src2;
            end
            U_SLL: begin
                result = src1 << shamt;
            end
            U_SRL: begin
                result = src1 >> shamt;
            end
            U_SRA: begin
                result = t_data'($signed(src1) >>> shamt);
            end
            U_SLT: begin
                result = t_data'($signed(src1) < $signed(src2));
            end
            U_SLTU: begin
                result = t_data'(src1 < src2);
            end
            // Upper immediate is already formed by decode
            U_LUI: begin
                result = src2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* ibr.sv */
module ibr
    import exe_pkg::*;
(
    input  t_uop  uop,
    input  t_data src1,
    input  t_data src2,
    input  t_data imm,
    input  t_data pc,
    input  logic  pred_taken,
    output logic  resvld,
    output t_data next_pc,
    output logic  mispred
);

    logic  taken;
    t_data jalr_tgt;

    assign resvld = is_br_uop(uop);

    // Condition resolution
    always_comb begin
        case (uop)
            U_BEQ:   taken = (src1 == src2);
            U_BNE:   taken = (src1 != src2);
            U_BLT:   taken = ($signed(src1) < $signed(src2));
            U_BGE:   taken = ($signed(src1) >= $signed(src2));
            U_BLTU:  taken = (src1 < src2);
            U_BGEU:  taken = (src1 >= src2);
            U_JAL:   taken = 1'b1;
            U_JALR:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        jalr_tgt    = src1 + imm;
        jalr_tgt[0] = 1'b0;
    end

    always_comb begin
        if (uop == U_JALR) begin
            next_pc = jalr_tgt;
        end else if (taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + t_data'(4);
        end
    end

    // Non-branch ops never flag a mispredict
    assign mispred = resvld & (taken != pred_taken);

endmodule

/* exe_pipe.sv */
module exe_pipe
    import exe_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        launch,
    input  logic        squash,
    input  t_iss_pkt    pkt,
    output logic        res_valid,
    output t_rob_result res
);

    t_data src2_ex0;

    logic  ialu_resvld_ex0;
    t_data ialu_result_ex0;

    logic  ibr_resvld_ex0;
    t_data ibr_tgt_ex0;
    logic  ibr_mispred_ex0;

    t_data result_ex0;
    logic  uop_invalid_ex0;

    // EX0 operand select
    always_comb begin
        case (pkt.src2_type)
            OP_REG:  src2_ex0 = pkt.src2_val;
            OP_IMM:  src2_ex0 = pkt.imm;
            default: src2_ex0 = '0;
        endcase
    end

    ialu ialu_i (
        .uop    (pkt.uop),
        .src1   (pkt.src1_val),
        .src2   (src2_ex0),
        .resvld (ialu_resvld_ex0),
        .result (ialu_result_ex0)
    );

    ibr ibr_i (
        .uop        (pkt.uop),
        .src1       (pkt.src1_val),
        .src2       (src2_ex0),
        .imm        (pkt.imm),
        .pc         (pkt.pc),
        .pred_taken (pkt.pred_taken),
        .resvld     (ibr_resvld_ex0),
        .next_pc    (ibr_tgt_ex0),
        .mispred    (ibr_mispred_ex0)
    );

    // At most one unit claims the op, so OR is enough
    assign result_ex0 = (ialu_resvld_ex0 ? ialu_result_ex0 : '0)
                      | (ibr_resvld_ex0  ? ibr_tgt_ex0     : '0);

    assign uop_invalid_ex0 = (pkt.uop == U_INVALID);

    // EX1
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= launch;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            res.robid   <= pkt.robid;
            res.result  <= squash ? '0 : result_ex0;
            res.mispred <= ~squash & ibr_mispred_ex0;
            res.killed  <= squash;
        end
    end

    a_one_unit: assert property (@(posedge clk) disable iff (!arst_n)
        launch && !squash |-> $onehot({uop_invalid_ex0, ialu_resvld_ex0, ibr_resvld_ex0}));

endmodule

/* iss_ctrl.sv */
module iss_ctrl
    import exe_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_req,
    input  logic        out_ack,
    input  logic        res_valid,
    input  t_rob_result res,
    input  logic        shadow_active,
    output logic        in_ack,
    output logic        out_req,
    output t_rob_result out_result,
    output logic        launch,
    output logic        squash,
    output logic        consume,
    output logic        arm
);

    typedef enum logic [2:0] {IDLE, EXEC, CAPTURE, DELIVER, RELEASE} t_state;

    t_state state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
            launch  <= 1'b0;
            squash  <= 1'b0;
            consume <= 1'b0;
            arm     <= 1'b0;
        end else begin
            launch  <= 1'b0;
            consume <= 1'b0;
            arm     <= 1'b0;
            // Input side finishes on its own once the producer lets go
            if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (in_req && !in_ack) begin
                        launch  <= 1'b1;
                        in_ack  <= 1'b1;
                        squash  <= shadow_active;
                        consume <= shadow_active;
                        state   <= EXEC;
                    end
                end
                EXEC: begin
                    state <= CAPTURE;
                end
                CAPTURE: begin
                    if (res_valid) begin
                        out_req <= 1'b1;
                        state   <= DELIVER;
                    end
                end
                DELIVER: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        arm     <= out_result.mispred;
                        state   <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!out_ack && !in_req && !in_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Output payload register
    always_ff @(posedge clk) begin
        if (state == CAPTURE && res_valid) begin
            out_result <= res;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_req && $past(out_req) |-> $stable(out_result));

    a_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req));

endmodule

/* shadow_counter.sv */
module shadow_counter #(
    parameter int SHADOW_DEPTH = 2
) (
    input  logic clk,
    input  logic arst_n,
    input  logic arm,
    input  logic consume,
    input  logic redirect,
    output logic shadow_active
);

    localparam int CNT_W = $clog2(SHADOW_DEPTH + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (redirect) begin
            // ROB redirect ends the wrong path outright
            count <= '0;
        end else if (arm) begin
            count <= CNT_W'(SHADOW_DEPTH);
        end else if (consume && count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign shadow_active = (count != '0);

    a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
        count <= CNT_W'(SHADOW_DEPTH));

endmodule

/* exe_top.sv */
module exe_top
    import exe_pkg::*;
#(
    parameter int SHADOW_DEPTH = 2
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_req,
    output logic        in_ack,
    input  t_iss_pkt    in_pkt,
    output logic        out_req,
    input  logic        out_ack,
    output t_rob_result out_result,
    input  logic        redirect
);

    logic        launch;
    logic        squash;
    logic        consume;
    logic        arm;
    logic        shadow_active;
    logic        res_valid;
    t_rob_result res;

    iss_ctrl iss_ctrl_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_req        (in_req),
        .out_ack       (out_ack),
        .res_valid     (res_valid),
        .res           (res),
        .shadow_active (shadow_active),
        .in_ack        (in_ack),
        .out_req       (out_req),
        .out_result    (out_result),
        .launch        (launch),
        .squash        (squash),
        .consume       (consume),
        .arm           (arm)
    );

    shadow_counter #(
        .SHADOW_DEPTH (SHADOW_DEPTH)
    ) shadow_counter_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .arm           (arm),
        .consume       (consume),
        .redirect      (redirect),
        .shadow_active (shadow_active)
    );

    exe_pipe exe_pipe_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .launch    (launch),
        .squash    (squash),
        .pkt       (in_pkt),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

/* tb_exe_top.sv */
module tb_exe_top
    import exe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TMO          = 40;
    localparam int SHADOW_DEPTH = 2;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        in_req;
    logic        in_ack;
    t_iss_pkt    in_pkt;
    logic        out_req;
    logic        out_ack;
    t_rob_result out_result;
    logic        redirect;

    // Reference model state
    t_rob_result exp_res;
    int          shadow_cnt;
    string       test_name;
    logic [31:0] rng;
    t_rob_id     next_id;
    int          n_issued;
    int          n_delivered;
    logic        out_req_q;

    t_uop alu_ops[11] = '{U_ADD, U_SUB, U_AND, U_OR, U_XOR, U_SLL, U_SRL, U_SRA,
                          U_SLT, U_SLTU, U_LUI};
    t_uop br_ops[8]   = '{U_BEQ, U_BNE, U_BLT, U_BGE, U_BLTU, U_BGEU, U_JAL, U_JALR};

    exe_top #(
        .SHADOW_DEPTH (SHADOW_DEPTH)
    ) dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_pkt     (in_pkt),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_result (out_result),
        .redirect   (redirect)
    );

    always #4 clk = ~clk;

    // Count delivered results by the rising edge of out_req
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_req_q   <= 1'b0;
            n_delivered <= 0;
        end else begin
            out_req_q <= out_req;
            if (out_req && !out_req_q) begin
                n_delivered <= n_delivered + 1;
            end
        end
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    a_result: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> out_result == exp_res)
        else fail_now($sformatf("[ERROR] %s: expected %h, actual %h",
                                test_name, exp_res, out_result));

    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_req && !out_ack |=> out_req && $stable(out_result))
        else fail_now("out_req dropped or out_result changed before out_ack");

    a_in_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
        in_ack && in_req |=> in_ack)
        else fail_now("in_ack dropped while in_req was still high");

    a_in_ack_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !in_ack && !in_req |=> !in_ack)
        else fail_now("in_ack rose without in_req");

    function automatic logic [31:0] rand_next();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic t_iss_pkt make_pkt(t_uop u, t_optype t, t_data a, t_data b,
                                          logic pred);
        t_iss_pkt p;
        p            = '0;
        p.uop        = u;
        p.src2_type  = t;
        p.src1_val   = a;
        p.src2_val   = b;
        p.imm        = rand_next();
        p.pc         = rand_next() & ~32'h3;
        p.pred_taken = pred;
        return p;
    endfunction

    function automatic t_rob_result predict_result(t_iss_pkt p, int shadow);
        t_rob_result r;
        t_data       a;
        t_data       b;
        logic        tk;
        r       = '0;
        r.robid = p.robid;
        if (shadow > 0) begin
            r.killed = 1'b1;
            return r;
        end
        a  = p.src1_val;
        b  = (p.src2_type == OP_REG) ? p.src2_val : (p.src2_type == OP_IMM) ? p.imm : '0;
        tk = 1'b0;
        case (p.uop)
            U_ADD:   r.result = a + b;
            U_SUB:   r.result = a - b;
            U_AND:   r.result = a & b;
            U_OR:    r.result = a | b;
            U_XOR:   r.result = a ^ b;
            U_SLL:   r.result = a << b[4:0];
            U_SRL:   r.result = a >> b[4:0];
            U_SRA:   r.result = $signed(a) >>> b[4:0];
            U_SLT:   r.result = {31'b0, $signed(a) < $signed(b)};
            U_SLTU:  r.result = {31'b0, a < b};
            U_LUI:   r.result = b;
            U_BEQ:   tk = (a == b);
            U_BNE:   tk = (a != b);
            U_BLT:   tk = ($signed(a) < $signed(b));
            U_BGE:   tk = !($signed(a) < $signed(b));
            U_BLTU:  tk = (a < b);
            U_BGEU:  tk = !(a < b);
            U_JAL:   tk = 1'b1;
            U_JALR:  tk = 1'b1;
            default: r.result = '0;
        endcase
        if (is_br_uop(p.uop)) begin
            if (p.uop == U_JALR) begin
                r.result = (a + p.imm) & ~32'h1;
            end else begin
                r.result = tk ? p.pc + p.imm : p.pc + 32'd4;
            end
            r.mispred = (tk != p.pred_taken);
        end
        return r;
    endfunction

    task automatic wait_level(input logic on_out, input logic level, input string what);
        int n;
        n = 0;
        while ((on_out ? out_req : in_ack) !== level) begin
            @(negedge clk);
            n++;
            if (n > TMO) begin
                fail_now({"Timeout waiting for ", what});
            end
        end
    endtask

    // One packet through both four-phase handshakes
    task automatic issue_pkt(input t_iss_pkt p);
        int delay;
        int hold;
        p.robid = next_id;
        next_id++;
        n_issued++;
        exp_res = predict_result(p, shadow_cnt);
        if (shadow_cnt > 0) begin
            shadow_cnt--;
        end
        delay = int'(rand_next() % 6);
        hold  = int'(rand_next() % 4);
        @(negedge clk);
        in_pkt = p;
        in_req = 1'b1;
        wait_level(1'b0, 1'b1, "in_ack to rise");
        // Producer keeps in_req up a while so in_ack has to hold
        repeat (hold) @(negedge clk);
        in_req = 1'b0;
        wait_level(1'b0, 1'b0, "in_ack to fall");
        wait_level(1'b1, 1'b1, "out_req to rise");
        repeat (delay) @(negedge clk);
        out_ack = 1'b1;
        wait_level(1'b1, 1'b0, "out_req to fall");
        out_ack = 1'b0;
        assert (n_delivered == n_issued)
            else fail_now($sformatf("[ERROR] %s: expected %0d results, actual %0d",
                                    test_name, n_issued, n_delivered));
        assert (out_result.robid == p.robid)
            else fail_now($sformatf("[ERROR] %s: expected rob id %0d, actual %0d",
                                    test_name, p.robid, out_result.robid));
        if (exp_res.mispred) begin
            shadow_cnt = SHADOW_DEPTH;
        end
    endtask

    task automatic pulse_redirect();
        @(negedge clk);
        redirect = 1'b1;
        @(negedge clk);
        redirect = 1'b0;
        shadow_cnt = 0;
    endtask

    initial begin
        t_data       a;
        t_data       b;
        t_data       r;
        logic [31:0] sel;
        t_uop        u;
        arst_n     = 1'b0;
        in_req     = 1'b0;
        in_pkt     = '0;
        out_ack    = 1'b0;
        redirect   = 1'b0;
        rng        = 32'he653;
        shadow_cnt = 0;
        next_id    = '0;
        n_issued   = 0;
        exp_res    = '0;
        test_name  = "reset";
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        test_name = "alu";
        foreach (alu_ops[i]) begin
            issue_pkt(make_pkt(alu_ops[i], OP_REG, rand_next(), rand_next(), 1'b0));
            issue_pkt(make_pkt(alu_ops[i], OP_IMM, rand_next(), rand_next(), 1'b0));
        end
        issue_pkt(make_pkt(U_OR, OP_ZERO, rand_next(), rand_next(), 1'b0));

        // Equal, signed less and mixed-sign pairs cover taken and not taken
        test_name = "branch";
        foreach (br_ops[i]) begin
            for (int k = 0; k < 3; k++) begin
                for (int pr = 0; pr < 2; pr++) begin
                    r = rand_next();
                    case (k)
                        0: begin
                            a = r;
                            b = r;
                        end
                        1: begin
                            a = r >> 2;
                            b = (r >> 2) + 32'd1;
                        end
                        default: begin
                            a = r | 32'h8000_0000;
                            b = r >> 1;
                        end
                    endcase
                    issue_pkt(make_pkt(br_ops[i], OP_REG, a, b, pr[0]));
                    pulse_redirect();
                end
            end
        end

        test_name = "shadow";
        issue_pkt(make_pkt(U_BEQ, OP_REG, 32'd5, 32'd5, 1'b0));
        repeat (3) issue_pkt(make_pkt(U_ADD, OP_IMM, rand_next(), rand_next(), 1'b0));

        test_name = "redirect";
        issue_pkt(make_pkt(U_BNE, OP_REG, 32'd9, 32'd9, 1'b1));
        issue_pkt(make_pkt(U_XOR, OP_REG, rand_next(), rand_next(), 1'b0));
        pulse_redirect();
        issue_pkt(make_pkt(U_SUB, OP_REG, rand_next(), rand_next(), 1'b0));

        test_name = "invalid";
        issue_pkt(make_pkt(U_INVALID, OP_REG, rand_next(), rand_next(), 1'b1));

        test_name = "random";
        repeat (60) begin
            sel = rand_next();
            if (sel[0]) begin
                u = alu_ops[int'(sel[8:1]) % 11];
            end else begin
                u = br_ops[int'(sel[8:1]) % 8];
            end
            issue_pkt(make_pkt(u, sel[9] ? OP_IMM : OP_REG, rand_next(), rand_next(),
                               sel[10]));
            if (sel[15:12] == 4'd0) begin
                pulse_redirect();
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* list.f */
exe_pkg.sv
ialu.sv
ibr.sv
exe_pipe.sv
iss_ctrl.sv
shadow_counter.sv
exe_top.sv
tb_exe_top.sv

/* Makefile */
TOP = tb_exe_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
